// File: all.f
design/fin_data_pkg.sv
design/fin_ctrl_pkg.sv
design/fin_credit_fifo.sv
design/fin_position_counter.sv
design/fin_buf_fsm.sv
design/fin_line_banks.sv
design/fin_window_shifter.sv
design/conv_fin_buf.sv
tests/tb_conv_fin_buf.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the conv_fin_buf testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing -j 0 -f all.f --top-module tb_conv_fin_buf -Mdir "$build_dir"
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit "$status"
fi

"./$build_dir/Vtb_conv_fin_buf"
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished cleanly"
exit 0

// File: tests/tb_conv_fin_buf.sv
`default_nettype none

module tb_conv_fin_buf;
	import fin_data_pkg::*;
	import fin_ctrl_pkg::*;

	localparam int KH = DEF_KH;
	localparam int STRIDE = DEF_STRIDE;
	localparam int LINE_NEED = DEF_LINE_NEED;
	localparam int LINE_WORDS = DEF_LINE_WORDS;
	localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
	localparam int BPL = LINE_WORDS / WORDS_PER_BEAT;
	localparam int OW = (LINE_WORDS - KH) / STRIDE + 1;
	localparam int WAIT_LIMIT = 500;	// cycles for any single wait

	logic clk;
	logic rst_n;
	logic fin_send;
	fin_beat_t fin_beat;
	logic fin_credit;
	word_t [LINE_NEED-1:0][KH-1:0] window;
	logic win_valid;
	logic win_next;

	fin_beat_t send_q[$];	// beats the source still has to send
	int credits;	// credits held by the source
	int errors;
	integer seed;

	conv_fin_buf #(
		.KH		(KH),
		.STRIDE		(STRIDE),
		.LINE_NEED	(LINE_NEED),
		.LINE_WORDS	(LINE_WORDS),
		.FIFO_DEPTH	(FIFO_DEPTH)
	) i_dut (
		.clk		(clk),
		.rst_n		(rst_n),
		.fin_send	(fin_send),
		.fin_beat	(fin_beat),
		.fin_credit	(fin_credit),
		.window		(window),
		.win_valid	(win_valid),
		.win_next	(win_next)
	);

	initial
		clk = 1'b0;
	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			$display("Done: errors found");
			$fatal(1, "value check failed");
		end
	endtask

	// word c of line r in group g
	function automatic word_t ref_word(input int g, input int r, input int c);
		return {8'(g) ^ 8'ha5, 8'(r) + 8'h10, 16'(c) * 16'h0101};
	endfunction

	function automatic fin_beat_t make_beat(input int g, input int r, input int b,
		input logic soc);
		fin_beat_t bt;
		for (int w = 0; w < WORDS_PER_BEAT; w++)
			bt.data[w] = ref_word(g, r, b * WORDS_PER_BEAT + w);
		bt.soc = soc;
		bt.sol = (b == 0);
		return bt;
	endfunction

	task automatic queue_group(input int g, input logic first);
		for (int r = 0; r < LINE_NEED; r++)
			for (int b = 0; b < BPL; b++)
				send_q.push_back(make_beat(g, r, b, first && r == 0 && b == 0));
	endtask

	// one clock; outputs are read after the edge, inputs set for the next one
	task automatic step();
		@(posedge clk);
		#1;
		if (fin_credit)
			credits++;
		if (credits > FIFO_DEPTH)
			abort_run("source holds more credits than the FIFO has slots");
		if (send_q.size() > 0 && credits > 0)
		begin
			fin_beat = send_q.pop_front();
			fin_send = 1'b1;
			credits--;	// spent on this beat
		end
		else
			fin_send = 1'b0;
	endtask

	task automatic wait_window(input string what, output int cycles);
		cycles = 0;
		while (!win_valid && cycles < WAIT_LIMIT)
		begin
			step();
			cycles++;
		end
		if (!win_valid)
			abort_run({"timed out waiting for ", what});
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((send_q.size() > 0 || credits < FIFO_DEPTH) && n < WAIT_LIMIT)
		begin
			step();
			check_eq("win_valid", 32'(win_valid), 32'h0);
			n++;
		end
		if (send_q.size() > 0 || credits < FIFO_DEPTH)
			abort_run("timed out waiting for all credits to come back");
	endtask

	task automatic check_window(input int g, input int w);
		for (int l = 0; l < LINE_NEED; l++)
			for (int k = 0; k < KH; k++)
				check_eq($sformatf("window[%0d][%0d] g%0d w%0d", l, k, g, w),
					window[l][k], ref_word(g, l, w * STRIDE + k));
	endtask

	task automatic next_window();
		win_next = 1'b1;
		step();
		win_next = 1'b0;
		check_eq("win_valid", 32'(win_valid), 32'h0);	// low right after win_next
	endtask

	// windows w0 up to OW-1 of group g, then win_next on the last one
	task automatic serve_rest(input int g, input int w0);
		int cycles;
		for (int w = w0; w < OW; w++)
		begin
			next_window();
			wait_window($sformatf("group %0d window %0d", g, w), cycles);
			check_eq("slide cycles", 32'(cycles), 32'(STRIDE + 1));
			check_window(g, w);
		end
		next_window();
	endtask

	task automatic reset_stays_idle();
		check_eq("win_valid", 32'(win_valid), 32'h0);
		check_eq("fin_credit", 32'(fin_credit), 32'h0);
		repeat (20)
		begin
			step();
			check_eq("win_valid", 32'(win_valid), 32'h0);
			check_eq("fin_credit", 32'(fin_credit), 32'h0);
		end
	endtask

	task automatic stray_beats_discarded();
		fin_beat_t bt;
		for (int i = 0; i < 6; i++)
		begin
			for (int w = 0; w < WORDS_PER_BEAT; w++)
				bt.data[w] = $random(seed);
			bt.soc = 1'b0;	// no channel start yet
			bt.sol = (i % BPL == 0);
			send_q.push_back(bt);
		end
		wait_drained();
		repeat (20)
		begin
			step();
			check_eq("win_valid", 32'(win_valid), 32'h0);
			check_eq("fin_credit", 32'(fin_credit), 32'h0);	// one credit per beat only
		end
	endtask

	task automatic first_window_matches();
		int cycles;
		queue_group(0, 1'b1);
		wait_window("group 0 window 0", cycles);
		check_window(0, 0);
	endtask

	task automatic slides_follow_stride();
		serve_rest(0, 1);
		repeat (40)
		begin
			step();
			check_eq("win_valid", 32'(win_valid), 32'h0);	// nothing left in the group
		end
	endtask

	task automatic credits_under_backpressure();
		int n;
		int cycles;
		int q_left;
		queue_group(1, 1'b0);
		queue_group(2, 1'b0);
		wait_window("group 1 window 0", cycles);
		n = 0;
		while (credits > 0 && n < WAIT_LIMIT)
		begin
			step();
			check_eq("win_valid", 32'(win_valid), 32'h1);
			n++;
		end
		if (credits > 0)
			abort_run("credits never ran out while the window was held");
		q_left = send_q.size();
		repeat (30)
		begin
			step();
			check_eq("fin_send", 32'(fin_send), 32'h0);
			check_eq("win_valid", 32'(win_valid), 32'h1);
			check_eq("queued beats", 32'(send_q.size()), 32'(q_left));
			check_window(1, 0);	// held window stays put
		end
		serve_rest(1, 1);
		wait_window("group 2 window 0", cycles);
		check_window(2, 0);
		serve_rest(2, 1);
		wait_drained();
		repeat (20)
		begin
			step();
			check_eq("fin_credit", 32'(fin_credit), 32'h0);	// every beat already paid back
			check_eq("win_valid", 32'(win_valid), 32'h0);
		end
	endtask

	initial
	begin
		seed = 32'hbdb229b1;
		rst_n = 1'b0;
		fin_send = 1'b0;
		fin_beat = '0;
		win_next = 1'b0;
		credits = FIFO_DEPTH;	// source starts full
		errors = 0;
		repeat (3)
			step();
		rst_n = 1'b1;
		reset_stays_idle();
		stray_beats_discarded();
		first_window_matches();
		slides_follow_stride();
		credits_under_backpressure();
		if (errors == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("Done: errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

// File: design/conv_fin_buf.sv
`default_nettype none

module conv_fin_buf #(
	parameter int KH = fin_ctrl_pkg::DEF_KH,
	parameter int STRIDE = fin_ctrl_pkg::DEF_STRIDE,
	parameter int LINE_NEED = fin_ctrl_pkg::DEF_LINE_NEED,
	parameter int LINE_WORDS = fin_ctrl_pkg::DEF_LINE_WORDS,
	parameter int FIFO_DEPTH = fin_ctrl_pkg::DEF_FIFO_DEPTH
) (
	input wire clk,
	input wire rst_n,
	input wire fin_send,
	input wire fin_data_pkg::fin_beat_t fin_beat,
	output logic fin_credit,
	output fin_data_pkg::word_t [LINE_NEED-1:0][KH-1:0] window,
	output logic win_valid,
	input wire win_next
);
	import fin_data_pkg::*;

	localparam int BPL = LINE_WORDS / WORDS_PER_BEAT;
	localparam int BEAT_W = (BPL > 1) ? $clog2(BPL) : 1;
	localparam int LINE_W = (LINE_NEED > 1) ? $clog2(LINE_NEED) : 1;
	localparam int COL_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

	fin_beat_t head;
	logic head_valid;
	logic pop;
	logic wr_en;
	logic beat_step, group_clear, col_step, col_clear;
	logic line_end, group_full, last_window;
	logic fill_start, slide_start, busy;
	logic [BEAT_W-1:0] beat_idx;
	logic [LINE_W-1:0] line_idx;
	logic [COL_W-1:0] rd_col;
	word_t [LINE_NEED-1:0] rd_words;

	fin_credit_fifo #(
		.FIFO_DEPTH	(FIFO_DEPTH)
	) i_fifo (
		.clk		(clk),
		.rst_n		(rst_n),
		.push		(fin_send),
		.push_beat	(fin_beat),
		.pop		(pop),
		.head		(head),
		.head_valid	(head_valid),
		.credit		(fin_credit)
	);

	fin_position_counter #(
		.KH		(KH),
		.STRIDE		(STRIDE),
		.LINE_NEED	(LINE_NEED),
		.LINE_WORDS	(LINE_WORDS)
	) i_cnt (
		.clk		(clk),
		.rst_n		(rst_n),
		.beat_step	(beat_step),
		.sol		(head.sol),
		.group_clear	(group_clear),
		.col_step	(col_step),
		.col_clear	(col_clear),
		.beat_idx	(beat_idx),
		.line_idx	(line_idx),
		.line_end	(line_end),
		.group_full	(group_full),
		.last_window	(last_window)
	);

	fin_buf_fsm i_fsm (
		.clk		(clk),
		.rst_n		(rst_n),
		.head		(head),
		.head_valid	(head_valid),
		.line_end	(line_end),
		.group_full	(group_full),
		.last_window	(last_window),
		.busy		(busy),
		.win_next	(win_next),
		.pop		(pop),
		.wr_en		(wr_en),
		.beat_step	(beat_step),
		.group_clear	(group_clear),
		.col_step	(col_step),
		.col_clear	(col_clear),
		.fill_start	(fill_start),
		.slide_start	(slide_start),
		.win_valid	(win_valid)
	);

	// the popped beat is written where the counter points
	fin_line_banks #(
		.LINE_NEED	(LINE_NEED),
		.LINE_WORDS	(LINE_WORDS)
	) i_banks (
		.clk		(clk),
		.wr_en		(wr_en),
		.wr_line	(line_idx),
		.wr_beat	(beat_idx),
		.wr_data	(head.data),
		.rd_col		(rd_col),
		.rd_words	(rd_words)
	);

	fin_window_shifter #(
		.KH		(KH),
		.STRIDE		(STRIDE),
		.LINE_NEED	(LINE_NEED),
		.LINE_WORDS	(LINE_WORDS)
	) i_shift (
		.clk		(clk),
		.rst_n		(rst_n),
		.fill_start	(fill_start),
		.slide_start	(slide_start),
		.rd_words	(rd_words),
		.rd_col		(rd_col),
		.window		(window),
		.busy		(busy)
	);

endmodule

`default_nettype wire

// File: design/fin_window_shifter.sv
`default_nettype none

module fin_window_shifter #(
	parameter int KH = fin_ctrl_pkg::DEF_KH,
	parameter int STRIDE = fin_ctrl_pkg::DEF_STRIDE,
	parameter int LINE_NEED = fin_ctrl_pkg::DEF_LINE_NEED,
	parameter int LINE_WORDS = fin_ctrl_pkg::DEF_LINE_WORDS,
	localparam int COL_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1,
	localparam int LEFT_W = $clog2(((KH > STRIDE) ? KH : STRIDE) + 1)
) (
	input wire clk,
	input wire rst_n,
	input wire fill_start,
	input wire slide_start,
	input wire fin_data_pkg::word_t [LINE_NEED-1:0] rd_words,
	output logic [COL_W-1:0] rd_col,
	output fin_data_pkg::word_t [LINE_NEED-1:0][KH-1:0] window,
	output logic busy
);

	logic [COL_W-1:0] base;	// column 0 of the current window
	logic [LEFT_W-1:0] rd_left;	// reads still to issue
	logic cap_vld;	// rd_words holds a requested column

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			base <= '0;
			rd_col <= '0;
			rd_left <= '0;
			cap_vld <= 1'b0;
		end
		else
		begin
			cap_vld <= (rd_left != '0);
			if (fill_start)
			begin
				base <= '0;
				rd_col <= '0;
				rd_left <= LEFT_W'(KH);
			end
			else if (slide_start)
			begin
				base <= base + COL_W'(STRIDE);
				rd_col <= base + COL_W'(KH);	// first column past the right edge
				rd_left <= LEFT_W'(STRIDE);
			end
			else if (rd_left != '0)
			begin
				rd_col <= rd_col + 1'b1;
				rd_left <= rd_left - 1'b1;
			end
		end
	end

	// each column enters on the right, older ones move one place left
	always_ff @(posedge clk)
	begin
		if (cap_vld)
		begin
			for (int l = 0; l < LINE_NEED; l++)
				window[l] <= {rd_words[l], window[l][KH-1:1]};
		end
	end

	// drops with the last read; its word is captured in that same cycle
	assign busy = (rd_left != '0);

endmodule

`default_nettype wire

// File: design/fin_line_banks.sv
`default_nettype none

module fin_line_banks #(
	parameter int LINE_NEED = fin_ctrl_pkg::DEF_LINE_NEED,
	parameter int LINE_WORDS = fin_ctrl_pkg::DEF_LINE_WORDS,
	localparam int BPL = LINE_WORDS / fin_data_pkg::WORDS_PER_BEAT,
	localparam int BEAT_W = (BPL > 1) ? $clog2(BPL) : 1,
	localparam int LINE_W = (LINE_NEED > 1) ? $clog2(LINE_NEED) : 1,
	localparam int COL_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1
) (
	input wire clk,
	input wire wr_en,
	input wire [LINE_W-1:0] wr_line,
	input wire [BEAT_W-1:0] wr_beat,
	input wire fin_data_pkg::beat_data_t wr_data,
	input wire [COL_W-1:0] rd_col,
	output fin_data_pkg::word_t [LINE_NEED-1:0] rd_words
);
	import fin_data_pkg::*;

	// one word-addressed line memory per bank
	word_t mem [LINE_NEED][LINE_WORDS];
	logic [COL_W-1:0] wr_base;

	assign wr_base = COL_W'(wr_beat) * COL_W'(WORDS_PER_BEAT);	// beat b starts at word 8*b

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			for (int w = 0; w < WORDS_PER_BEAT; w++)
				mem[wr_line][wr_base + COL_W'(w)] <= wr_data[w];
		end
		// same column of every line, one cycle later
		for (int l = 0; l < LINE_NEED; l++)
			rd_words[l] <= mem[l][rd_col];
	end

endmodule

`default_nettype wire

// File: design/fin_buf_fsm.sv
`default_nettype none

module fin_buf_fsm (
	input wire clk,
	input wire rst_n,
	input wire fin_data_pkg::fin_beat_t head,
	input wire head_valid,
	input wire line_end,
	input wire group_full,
	input wire last_window,
	input wire busy,
	input wire win_next,
	output logic pop,
	output logic wr_en,
	output logic beat_step,
	output logic group_clear,
	output logic col_step,
	output logic col_clear,
	output logic fill_start,
	output logic slide_start,
	output logic win_valid
);
	import fin_ctrl_pkg::*;

	fin_state_t state;
	fin_state_t state_nxt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		pop = 1'b0;
		wr_en = 1'b0;
		beat_step = 1'b0;
		group_clear = 1'b0;
		fill_start = 1'b0;
		slide_start = 1'b0;
		case (state)
			IDLE:
			begin
				if (head_valid && head.soc)
				begin
					group_clear = 1'b1;	// soc beat stays at the head for LOAD
					state_nxt = LOAD;
				end
				else
					pop = head_valid;	// stray beats, credit still goes back
			end
			LOAD:
			begin
				pop = head_valid;
				wr_en = head_valid;
				beat_step = head_valid;
				// last beat of the last line completes the group
				if (head_valid && line_end && group_full)
				begin
					fill_start = 1'b1;
					state_nxt = FILL;
				end
			end
			FILL, SLIDE:
			begin
				if (!busy)
					state_nxt = SERVE;	// final read word lands this cycle
			end
			SERVE:
			begin
				if (win_next)
				begin
					slide_start = !last_window;
					state_nxt = last_window ? LOAD : SLIDE;
				end
			end
			default:
				state_nxt = IDLE;
		endcase
	end

	assign col_clear = fill_start;
	assign col_step = slide_start;
	assign win_valid = (state == SERVE);

endmodule

`default_nettype wire

// File: design/fin_position_counter.sv
`default_nettype none

module fin_position_counter #(
	parameter int KH = fin_ctrl_pkg::DEF_KH,
	parameter int STRIDE = fin_ctrl_pkg::DEF_STRIDE,
	parameter int LINE_NEED = fin_ctrl_pkg::DEF_LINE_NEED,
	parameter int LINE_WORDS = fin_ctrl_pkg::DEF_LINE_WORDS,
	localparam int BPL = LINE_WORDS / fin_data_pkg::WORDS_PER_BEAT,
	localparam int OW = (LINE_WORDS - KH) / STRIDE + 1,
	localparam int BEAT_W = (BPL > 1) ? $clog2(BPL) : 1,
	localparam int LINE_W = (LINE_NEED > 1) ? $clog2(LINE_NEED) : 1,
	localparam int COL_W = (OW > 1) ? $clog2(OW) : 1
) (
	input wire clk,
	input wire rst_n,
	input wire beat_step,
	input wire sol,
	input wire group_clear,
	input wire col_step,
	input wire col_clear,
	output logic [BEAT_W-1:0] beat_idx,
	output logic [LINE_W-1:0] line_idx,
	output logic line_end,
	output logic group_full,
	output logic last_window
);

	logic [BEAT_W-1:0] beat_cnt;
	logic [LINE_W-1:0] line_cnt;
	logic [COL_W-1:0] col_cnt;

	// position of the beat at the FIFO head, sol realigns it to word 0
	assign beat_idx = sol ? '0 : beat_cnt;
	assign line_idx = line_cnt;
	assign line_end = (beat_idx == BEAT_W'(BPL - 1));
	assign group_full = (line_cnt == LINE_W'(LINE_NEED - 1));	// writing the last bank
	assign last_window = (col_cnt == COL_W'(OW - 1));

	// beats in a line, lines in a group; banks taken round robin
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			beat_cnt <= '0;
			line_cnt <= '0;
		end
		else if (group_clear)
		begin
			beat_cnt <= '0;
			line_cnt <= '0;
		end
		else if (beat_step)
		begin
			if (line_end)
			begin
				beat_cnt <= '0;
				line_cnt <= group_full ? '0 : line_cnt + 1'b1;
			end
			else
				beat_cnt <= beat_idx + 1'b1;
		end
	end

	// output column of the window being served
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			col_cnt <= '0;
		else if (col_clear)
			col_cnt <= '0;
		else if (col_step)
			col_cnt <= col_cnt + 1'b1;
	end

endmodule

`default_nettype wire

// File: design/fin_credit_fifo.sv
`default_nettype none

module fin_credit_fifo #(
	parameter int FIFO_DEPTH = fin_ctrl_pkg::DEF_FIFO_DEPTH
) (
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire fin_data_pkg::fin_beat_t push_beat,
	input wire pop,
	output fin_data_pkg::fin_beat_t head,
	output logic head_valid,
	output logic credit
);
	import fin_data_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	fin_beat_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_beat;	// source never pushes without a credit
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			credit <= pop;	// one credit back per beat taken
		end
	end

	assign head = mem[rd_ptr];
	assign head_valid = (count != '0);

endmodule

`default_nettype wire

// File: design/fin_ctrl_pkg.sv
`default_nettype none

// control encodings and default layer geometry
package fin_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,	// waiting for a channel start
		LOAD,	// writing a group of lines into the banks
		FILL,	// first KH columns of the window
		SLIDE,	// STRIDE new columns after a win_next
		SERVE	// window held for the consumer
	} fin_state_t;

	// first layer: 11x11 kernel, stride 4
	localparam int DEF_KH = 11;
	localparam int DEF_STRIDE = 4;
	localparam int DEF_LINE_NEED = 6;
	localparam int DEF_LINE_WORDS = 32;	// multiple of 8 only
	localparam int DEF_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// File: design/fin_data_pkg.sv
`default_nettype none

// payload types shared by the input path and the line memories
package fin_data_pkg;

	// one single-precision feature value
	typedef logic [31:0] word_t;

	localparam int WORDS_PER_BEAT = 8;	// words in a 256-bit DDR beat

	// word 0 sits in the low bits, word 7 in the top bits
	typedef word_t [WORDS_PER_BEAT-1:0] beat_data_t;

	typedef struct packed {
		beat_data_t	data;
		logic		soc;	// first beat of a channel
		logic		sol;	// first beat of a line
	} fin_beat_t;

endpackage

`default_nettype wire
